// ==== rtl/coreDefsPkg.sv ====
// Core widths, instruction class, ALU operation and step enums, decoded instruction struct
package coreDefsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 4;
    localparam int numRegs = 16;
    localparam int immWidth = 20;

    typedef enum logic [3:0] {
        branch,
        memLoad,
        memStore,
        directSet,
        directOr,
        aluReg,
        aluImm,
        regMove,
        coreHalt,
        coreMode,
        illegal
    } instrClassT;

    // Codes 12 and up have no operation
    typedef enum logic [4:0] {
        opAdd = 5'd0,
        opSub = 5'd1,
        opAnd = 5'd2,
        opOr = 5'd3,
        opXor = 5'd4,
        opNot = 5'd5,
        opShl = 5'd6,
        opAsr = 5'd7,
        opLsr = 5'd8,
        opRor = 5'd9,
        opRol = 5'd10,
        opBic = 5'd11,
        opNone = 5'd12
    } aluOpT;

    typedef enum logic [2:0] {
        stepReset,
        stepFetch,
        stepDecode,
        stepExecute,
        stepMemory,
        stepWrite,
        stepSkip,
        stepHalt
    } stepT;

    typedef struct packed {
        instrClassT instrClass;
        aluOpT aluOp;
        logic [regAddrWidth-1:0] regA;
        logic [regAddrWidth-1:0] regB;
        logic [regAddrWidth-1:0] regDst;
        logic [3:0] cond;
        logic [immWidth-1:0] imm;
        logic [7:0] shortImm;
        logic [3:0] shift;
    } decodedInstT;

endpackage

// ==== rtl/regPortIf.sv ====
// Register file port bundle with core-side and register-side modports
`timescale 1ns/1ps

interface regPortIf;

    logic [coreDefsPkg::regAddrWidth-1:0] rdAddrA;
    logic [coreDefsPkg::regAddrWidth-1:0] rdAddrB;
    logic [coreDefsPkg::dataWidth-1:0] rdDataA;
    logic [coreDefsPkg::dataWidth-1:0] rdDataB;
    logic wrEn;
    logic [coreDefsPkg::regAddrWidth-1:0] wrAddr;
    logic [coreDefsPkg::dataWidth-1:0] wrData;

    modport core (
        output rdAddrA, rdAddrB, wrEn, wrAddr, wrData,
        input rdDataA, rdDataB
    );

    modport regs (
        input rdAddrA, rdAddrB, wrEn, wrAddr, wrData,
        output rdDataA, rdDataB
    );

endinterface

// ==== rtl/generalRegs.sv ====
// Sixteen general registers with two combinational read ports and one write port
`timescale 1ns/1ps

module generalRegs (
    input logic iClk,
    input logic rst,
    regPortIf.regs regs
);

    logic [coreDefsPkg::dataWidth-1:0] regFile [coreDefsPkg::numRegs];

    always_ff @(posedge iClk) begin
        if (rst) begin
            for (int i = 0; i < coreDefsPkg::numRegs; i++) begin
                regFile[i] <= '0;
            end
        end else if (regs.wrEn) begin
            regFile[regs.wrAddr] <= regs.wrData;
        end
    end

    assign regs.rdDataA = regFile[regs.rdAddrA];
    assign regs.rdDataB = regFile[regs.rdAddrB];

    // Destination index comes from the decoder, must always be resolved
    assert property (@(posedge iClk) disable iff (rst) !$isunknown(regs.wrAddr));

endmodule

// ==== rtl/instrDecoder.sv ====
// Instruction register and field decode into the decoded instruction struct
`timescale 1ns/1ps

module instrDecoder (
    input logic iClk,
    input logic rst,
    input coreDefsPkg::stepT step,
    input logic [coreDefsPkg::dataWidth-1:0] instrWord,
    output coreDefsPkg::decodedInstT decoded
);

    logic [coreDefsPkg::dataWidth-1:0] instrReg;

    always_ff @(posedge iClk) begin
        if (rst) begin
            instrReg <= '0;
        end else if (step == coreDefsPkg::stepFetch) begin
            instrReg <= instrWord;
        end
    end

    // Class is set by the position of the leading one
    always_comb begin
        decoded = '0;
        decoded.instrClass = coreDefsPkg::illegal;
        decoded.aluOp = coreDefsPkg::opNone;
        decoded.imm = instrReg[19:0];
        decoded.shortImm = instrReg[7:0];
        if (instrReg[31]) begin
            // Only the plain conditional branch form
            if (instrReg[30:28] == 3'b000) begin
                decoded.instrClass = coreDefsPkg::branch;
            end
            decoded.cond = instrReg[27:24];
            decoded.regA = instrReg[23:20];
        end else if (instrReg[30]) begin
            decoded.instrClass = instrReg[29] ? coreDefsPkg::memStore : coreDefsPkg::memLoad;
            decoded.regA = instrReg[27:24];
            decoded.regB = instrReg[23:20];
            decoded.regDst = instrReg[23:20];
        end else if (instrReg[29]) begin
            decoded.instrClass = instrReg[28] ? coreDefsPkg::directOr : coreDefsPkg::directSet;
            decoded.regA = instrReg[27:24];
            decoded.regDst = instrReg[27:24];
            decoded.shift = instrReg[23:20];
        end else if (instrReg[28]) begin
            decoded.instrClass = instrReg[27] ? coreDefsPkg::aluImm : coreDefsPkg::aluReg;
            if (instrReg[24:20] < 5'd12) begin
                decoded.aluOp = coreDefsPkg::aluOpT'(instrReg[24:20]);
            end
            decoded.regDst = instrReg[19:16];
            decoded.regA = instrReg[15:12];
            decoded.regB = instrReg[11:8];
            decoded.shift = instrReg[11:8];
        end else if (instrReg[27]) begin
            decoded.instrClass = coreDefsPkg::regMove;
            decoded.regDst = instrReg[23:20];
            decoded.regB = instrReg[19:16];
        end else if (instrReg[26]) begin
            case (instrReg[25:20])
                6'd2: decoded.instrClass = coreDefsPkg::coreHalt;
                6'd3: decoded.instrClass = coreDefsPkg::coreMode;
                default: decoded.instrClass = coreDefsPkg::illegal;
            endcase
        end
    end

endmodule

// ==== rtl/aluUnit.sv ====
// Arithmetic/logic unit with carry and overflow outputs
`timescale 1ns/1ps

module aluUnit (
    input coreDefsPkg::aluOpT op,
    input logic [coreDefsPkg::dataWidth-1:0] opA,
    input logic [coreDefsPkg::dataWidth-1:0] opB,
    input logic carryIn,
    output logic [coreDefsPkg::dataWidth-1:0] result,
    output logic carryOut,
    output logic overflow
);

    logic [coreDefsPkg::dataWidth:0] wide;
    logic [coreDefsPkg::dataWidth:0] carryExt;
    logic [4:0] rotAmt;
    logic signA, signB, signR;

    assign carryExt = {{coreDefsPkg::dataWidth{1'b0}}, carryIn};
    assign rotAmt = opB[4:0];

    // Bit 32 collects the carry or the bit shifted out on the left
    always_comb begin
        case (op)
            coreDefsPkg::opAdd: wide = {1'b0, opA} + {1'b0, opB} + carryExt;
            coreDefsPkg::opSub: wide = {1'b0, opA} - ({1'b0, opB} + carryExt);
            coreDefsPkg::opAnd: wide = {1'b0, opA & opB};
            coreDefsPkg::opOr: wide = {1'b0, opA | opB};
            coreDefsPkg::opXor: wide = {1'b0, opA ^ opB};
            coreDefsPkg::opNot: wide = {1'b0, ~opA};
            coreDefsPkg::opShl: wide = {1'b0, opA} << opB;
            coreDefsPkg::opAsr: wide = {1'b0, $signed(opA) >>> opB};
            coreDefsPkg::opLsr: wide = {1'b0, opA >> opB};
            coreDefsPkg::opRor: wide = {1'b0, (opA >> rotAmt) | (opA << (6'd32 - rotAmt))};
            coreDefsPkg::opRol: wide = {1'b0, (opA << rotAmt) | (opA >> (6'd32 - rotAmt))};
            coreDefsPkg::opBic: wide = {1'b0, opA & ~opB};
            default: wide = '0;
        endcase
    end

    assign result = wide[coreDefsPkg::dataWidth-1:0];
    assign carryOut = wide[coreDefsPkg::dataWidth];

    assign signA = opA[coreDefsPkg::dataWidth-1];
    assign signB = opB[coreDefsPkg::dataWidth-1];
    assign signR = wide[coreDefsPkg::dataWidth-1];

    always_comb begin
        case (op)
            coreDefsPkg::opAdd: overflow = (signA == signB) && (signR != signA);
            coreDefsPkg::opSub: overflow = (signA != signB) && (signR != signA);
            default: overflow = 1'b0;
        endcase
    end

endmodule

// ==== rtl/statusRegs.sv ====
// Status and mode register with flag updates and branch condition evaluation
`timescale 1ns/1ps

module statusRegs (
    input logic iClk,
    input logic rst,
    input coreDefsPkg::stepT step,
    input coreDefsPkg::decodedInstT decoded,
    input logic [coreDefsPkg::dataWidth-1:0] aluResult,
    input logic carryOut,
    input logic overflow,
    output logic carryFlag,
    output logic signExtend,
    output logic condTrue
);

    logic zeroFlag, negFlag, overFlag, flagSet;
    logic isAlu;

    assign isAlu = decoded.instrClass inside {coreDefsPkg::aluReg, coreDefsPkg::aluImm};

    always_ff @(posedge iClk) begin
        if (rst) begin
            carryFlag <= 1'b0;
            zeroFlag <= 1'b0;
            negFlag <= 1'b0;
            overFlag <= 1'b0;
            flagSet <= 1'b0;
            signExtend <= 1'b0;
        end else if (step == coreDefsPkg::stepWrite) begin
            if (isAlu && flagSet) begin
                carryFlag <= carryOut;
                zeroFlag <= (aluResult == '0);
                negFlag <= aluResult[coreDefsPkg::dataWidth-1];
                overFlag <= overflow;
            end
            if (decoded.instrClass == coreDefsPkg::coreMode) begin
                flagSet <= decoded.imm[1];
                signExtend <= decoded.imm[0];
            end
        end
    end

    always_comb begin
        condTrue = 1'b1;
        if (decoded.instrClass == coreDefsPkg::branch) begin
            case (decoded.cond)
                4'd0: condTrue = 1'b1;
                4'd1: condTrue = zeroFlag;
                4'd2: condTrue = !zeroFlag;
                4'd3: condTrue = carryFlag;
                4'd4: condTrue = !carryFlag;
                4'd5: condTrue = negFlag;
                4'd6: condTrue = !negFlag;
                4'd7: condTrue = overFlag;
                4'd8: condTrue = !overFlag;
                4'd9: condTrue = carryFlag && !zeroFlag;
                4'd10: condTrue = !carryFlag || zeroFlag;
                4'd11: condTrue = (negFlag == overFlag);
                4'd12: condTrue = (negFlag != overFlag);
                4'd13: condTrue = !zeroFlag && (negFlag == overFlag);
                4'd14: condTrue = zeroFlag || (negFlag != overFlag);
                default: condTrue = 1'b0;
            endcase
        end
    end

    // Sequencer picks write or skip from this in the memory step
    assert property (@(posedge iClk) disable iff (rst)
        step == coreDefsPkg::stepMemory |-> !$isunknown(condTrue));

endmodule

// ==== rtl/stepSequencer.sv ====
// Instruction step FSM and registered halt output
`timescale 1ns/1ps

module stepSequencer (
    input logic iClk,
    input logic rst,
    input coreDefsPkg::decodedInstT decoded,
    input logic condTrue,
    output coreDefsPkg::stepT step,
    output logic halt
);

    coreDefsPkg::stepT nextStep;
    logic isHalt;

    assign isHalt = (decoded.instrClass == coreDefsPkg::coreHalt);

    always_comb begin
        case (step)
            coreDefsPkg::stepReset: nextStep = coreDefsPkg::stepFetch;
            coreDefsPkg::stepFetch: nextStep = coreDefsPkg::stepDecode;
            coreDefsPkg::stepDecode: nextStep = coreDefsPkg::stepExecute;
            coreDefsPkg::stepExecute: nextStep = coreDefsPkg::stepMemory;
            coreDefsPkg::stepMemory:
                nextStep = condTrue ? coreDefsPkg::stepWrite : coreDefsPkg::stepSkip;
            coreDefsPkg::stepWrite, coreDefsPkg::stepSkip:
                nextStep = isHalt ? coreDefsPkg::stepHalt : coreDefsPkg::stepFetch;
            coreDefsPkg::stepHalt: nextStep = coreDefsPkg::stepHalt;
            default: nextStep = coreDefsPkg::stepReset;
        endcase
    end

    always_ff @(posedge iClk) begin
        if (rst) begin
            step <= coreDefsPkg::stepReset;
            halt <= 1'b0;
        end else begin
            step <= nextStep;
            // Rises together with entry into stepHalt
            halt <= (nextStep == coreDefsPkg::stepHalt);
        end
    end

    assert property (@(posedge iClk) disable iff (rst) !$isunknown(step));

endmodule

// ==== rtl/cpuCore.sv ====
// Multi-cycle core top level with IP, operand, memory and result registers and bus muxing
`timescale 1ns/1ps

module cpuCore (
    input logic iClk,
    input logic rst,
    output logic [coreDefsPkg::dataWidth-1:0] memAddr,
    output logic memWrite,
    output logic [coreDefsPkg::dataWidth-1:0] memWrData,
    input logic [coreDefsPkg::dataWidth-1:0] memRdData,
    output logic halt
);

    coreDefsPkg::stepT step;
    coreDefsPkg::decodedInstT decoded;
    coreDefsPkg::instrClassT instrClass;
    coreDefsPkg::aluOpT aluOp;
    logic [coreDefsPkg::dataWidth-1:0] ip, opA, opB, mdr, nextOpB;
    logic [coreDefsPkg::dataWidth-1:0] aluA, aluResult, immSext, immZext, shortZext;
    logic [coreDefsPkg::dataWidth:0] resultReg;
    logic aluCarryIn, aluCarryOut, aluOverflow;
    logic carryFlag, signExtend, condTrue;
    logic isMem, writesReg;

    regPortIf regBus ();

    generalRegs regFile (.iClk(iClk), .rst(rst), .regs(regBus.regs));

    instrDecoder decoder (
        .iClk(iClk), .rst(rst), .step(step), .instrWord(memRdData), .decoded(decoded)
    );

    stepSequencer sequencer (
        .iClk(iClk), .rst(rst), .decoded(decoded), .condTrue(condTrue),
        .step(step), .halt(halt)
    );

    // Operands hold until writeback, so the live overflow still matches resultReg
    statusRegs statusBlock (
        .iClk(iClk), .rst(rst), .step(step), .decoded(decoded),
        .aluResult(resultReg[coreDefsPkg::dataWidth-1:0]),
        .carryOut(resultReg[coreDefsPkg::dataWidth]), .overflow(aluOverflow),
        .carryFlag(carryFlag), .signExtend(signExtend), .condTrue(condTrue)
    );

    aluUnit alu (
        .op(aluOp), .opA(aluA), .opB(opB), .carryIn(aluCarryIn),
        .result(aluResult), .carryOut(aluCarryOut), .overflow(aluOverflow)
    );

    assign instrClass = decoded.instrClass;
    assign isMem = instrClass inside {coreDefsPkg::memLoad, coreDefsPkg::memStore};
    assign writesReg = instrClass inside {coreDefsPkg::memLoad, coreDefsPkg::directSet,
        coreDefsPkg::directOr, coreDefsPkg::aluReg, coreDefsPkg::aluImm, coreDefsPkg::regMove};

    assign immSext = {{(coreDefsPkg::dataWidth-coreDefsPkg::immWidth){decoded.imm[19]}},
        decoded.imm};
    assign immZext = {{(coreDefsPkg::dataWidth-coreDefsPkg::immWidth){1'b0}}, decoded.imm};
    assign shortZext = {24'h0, decoded.shortImm};

    // Operand B source, picked in decode
    always_comb begin
        case (instrClass)
            coreDefsPkg::branch: nextOpB = immSext;
            coreDefsPkg::memLoad, coreDefsPkg::memStore: nextOpB = signExtend ? immSext : immZext;
            coreDefsPkg::directSet, coreDefsPkg::directOr:
                nextOpB = immZext << {decoded.shift, 1'b0};
            coreDefsPkg::aluImm: nextOpB = shortZext << {decoded.shift, 1'b0};
            default: nextOpB = regBus.rdDataB;
        endcase
    end

    always_comb begin
        aluA = opA;
        aluCarryIn = 1'b0;
        case (instrClass)
            coreDefsPkg::branch, coreDefsPkg::memLoad, coreDefsPkg::memStore:
                aluOp = coreDefsPkg::opAdd;
            coreDefsPkg::directSet: begin
                aluOp = coreDefsPkg::opOr;
                aluA = '0;
            end
            coreDefsPkg::directOr: aluOp = coreDefsPkg::opOr;
            coreDefsPkg::aluReg, coreDefsPkg::aluImm: begin
                aluOp = decoded.aluOp;
                aluCarryIn = carryFlag;
            end
            default: aluOp = coreDefsPkg::opNone;
        endcase
    end

    always_ff @(posedge iClk) begin
        if (step == coreDefsPkg::stepDecode) begin
            opA <= regBus.rdDataA;
            opB <= nextOpB;
        end
        if (step == coreDefsPkg::stepExecute) begin
            resultReg <= {aluCarryOut, aluResult};
        end
    end

    // Store data in decode, load data in memory
    always_ff @(posedge iClk) begin
        if (step == coreDefsPkg::stepDecode) begin
            mdr <= regBus.rdDataB;
        end else if (step == coreDefsPkg::stepMemory && instrClass == coreDefsPkg::memLoad) begin
            mdr <= memRdData;
        end
    end

    always_ff @(posedge iClk) begin
        if (rst) begin
            ip <= '0;
        end else if (step == coreDefsPkg::stepWrite && instrClass == coreDefsPkg::branch) begin
            ip <= resultReg[coreDefsPkg::dataWidth-1:0];
        end else if (step == coreDefsPkg::stepWrite || step == coreDefsPkg::stepSkip) begin
            ip <= ip + 32'd1;
        end
    end

    assign regBus.rdAddrA = decoded.regA;
    assign regBus.rdAddrB = decoded.regB;
    assign regBus.wrAddr = decoded.regDst;
    assign regBus.wrEn = (step == coreDefsPkg::stepWrite) && writesReg;

    always_comb begin
        case (instrClass)
            coreDefsPkg::memLoad: regBus.wrData = mdr;
            coreDefsPkg::regMove: regBus.wrData = opB;
            default: regBus.wrData = resultReg[coreDefsPkg::dataWidth-1:0];
        endcase
    end

    always_comb begin
        if (step == coreDefsPkg::stepFetch) begin
            memAddr = ip;
        end else if (step == coreDefsPkg::stepMemory && isMem) begin
            memAddr = resultReg[coreDefsPkg::dataWidth-1:0];
        end else begin
            memAddr = '0;
        end
    end

    assign memWrite = (step == coreDefsPkg::stepMemory) && (instrClass == coreDefsPkg::memStore);
    assign memWrData = mdr;

endmodule

// ==== verif/cpuCoreTb.sv ====
// Testbench for cpuCore with memory model, program builders, reference interpreter and store checks
`timescale 1ns/1ps

module cpuCoreTb;

    logic iClk;
    logic rst;
    logic [31:0] memAddr, memWrData, memRdData;
    logic memWrite, halt;

    logic [31:0] mem [logic [31:0]];
    logic [31:0] prog [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    int memVersion;
    int storeCount;
    int slot;

    cpuCore i_dut (
        .iClk(iClk), .rst(rst), .memAddr(memAddr), .memWrite(memWrite),
        .memWrData(memWrData), .memRdData(memRdData), .halt(halt)
    );

    always #2 iClk = ~iClk;

    function automatic logic [31:0] fillWord(input logic [31:0] a);
        return (a * 32'h9E3779B1) ^ 32'h5A5A0F0F;
    endfunction

    // Zero-wait memory with read data following the address in the same cycle
    always @(memAddr, memVersion) begin
        memRdData = mem.exists(memAddr) ? mem[memAddr] : fillWord(memAddr);
    end

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stopRun($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // Instruction encoders
    function automatic logic [31:0] branchInstr(input int cond, input int base, input int off);
        return {4'b1000, cond[3:0], base[3:0], off[19:0]};
    endfunction

    function automatic logic [31:0] memInstr(input int store, input int base, input int rg,
        input int off);
        return {2'b01, store[0], 1'b0, base[3:0], rg[3:0], off[19:0]};
    endfunction

    function automatic logic [31:0] directInstr(input int isOr, input int rg, input int sh,
        input int imm);
        return {3'b001, isOr[0], rg[3:0], sh[3:0], imm[19:0]};
    endfunction

    function automatic logic [31:0] aluInstr(input int isImm, input int op, input int dst,
        input int a, input int b, input int imm8);
        return {4'b0001, isImm[0], 2'b00, op[4:0], dst[3:0], a[3:0], b[3:0], imm8[7:0]};
    endfunction

    function automatic logic [31:0] moveInstr(input int dst, input int src);
        return {5'b00001, 3'b000, dst[3:0], src[3:0], 16'h0};
    endfunction

    function automatic logic [31:0] coreInstr(input int op, input int imm);
        return {6'b000001, op[5:0], imm[19:0]};
    endfunction

    function automatic logic [31:0] sext20(input logic [19:0] x);
        return {{12{x[19]}}, x};
    endfunction

    function automatic logic condHolds(input logic [3:0] cond, input logic c, input logic z,
        input logic n, input logic v);
        case (cond)
            4'd0: return 1'b1;
            4'd1: return z;
            4'd2: return !z;
            4'd3: return c;
            4'd4: return !c;
            4'd5: return n;
            4'd6: return !n;
            4'd7: return v;
            4'd8: return !v;
            4'd9: return c && !z;
            4'd10: return !c || z;
            4'd11: return n == v;
            4'd12: return n != v;
            4'd13: return !z && (n == v);
            4'd14: return z || (n != v);
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] aluRef(input logic [4:0] op, input logic [31:0] a,
        input logic [31:0] b, input logic cin, output logic co, output logic ov);
        logic [32:0] w;
        logic [4:0] r;
        w = '0;
        r = b[4:0];
        case (op)
            5'd0: w = {1'b0, a} + {1'b0, b} + {32'h0, cin};
            5'd1: w = {1'b0, a} - ({1'b0, b} + {32'h0, cin});
            5'd2: w[31:0] = a & b;
            5'd3: w[31:0] = a | b;
            5'd4: w[31:0] = a ^ b;
            5'd5: w[31:0] = ~a;
            5'd6: w = {1'b0, a} << b;
            5'd7: w[31:0] = $signed(a) >>> b;
            5'd8: w[31:0] = a >> b;
            5'd9: w[31:0] = (r == 5'd0) ? a : ((a >> r) | (a << (32 - int'(r))));
            5'd10: w[31:0] = (r == 5'd0) ? a : ((a << r) | (a >> (32 - int'(r))));
            5'd11: w[31:0] = a & ~b;
            default: w = '0;
        endcase
        co = w[32];
        ov = 1'b0;
        if (op == 5'd0) ov = (a[31] == b[31]) && (w[31] != a[31]);
        if (op == 5'd1) ov = (a[31] != b[31]) && (w[31] != a[31]);
        return w[31:0];
    endfunction

    // Instruction-level interpreter that returns the number of instructions up to halt
    function automatic int runReference();
        logic [31:0] r [16];
        logic [31:0] m [logic [31:0]];
        logic [31:0] ip, nextIp, w, b, res, addr;
        logic c, z, n, v, fs, se, co, ov;
        m = mem;
        for (int i = 0; i < 16; i++) r[i] = '0;
        {ip, c, z, n, v, fs, se} = '0;
        expAddr.delete();
        expData.delete();
        for (int steps = 1; steps <= 5000; steps++) begin
            w = m.exists(ip) ? m[ip] : fillWord(ip);
            nextIp = ip + 32'd1;
            if (w[31]) begin
                if (w[30:28] == 3'b000 && condHolds(w[27:24], c, z, n, v))
                    nextIp = r[w[23:20]] + sext20(w[19:0]);
            end else if (w[30]) begin
                addr = r[w[27:24]] + (se ? sext20(w[19:0]) : {12'h0, w[19:0]});
                if (w[29]) begin
                    m[addr] = r[w[23:20]];
                    expAddr.push_back(addr);
                    expData.push_back(r[w[23:20]]);
                end else begin
                    r[w[23:20]] = m.exists(addr) ? m[addr] : fillWord(addr);
                end
            end else if (w[29]) begin
                b = {12'h0, w[19:0]} << (2 * w[23:20]);
                r[w[27:24]] = w[28] ? (r[w[27:24]] | b) : b;
            end else if (w[28]) begin
                b = w[27] ? ({24'h0, w[7:0]} << (2 * w[11:8])) : r[w[11:8]];
                res = aluRef(w[24:20], r[w[15:12]], b, c, co, ov);
                if (fs) begin
                    c = co;
                    z = (res == 32'h0);
                    n = res[31];
                    v = ov;
                end
                r[w[19:16]] = res;
            end else if (w[27]) begin
                r[w[23:20]] = r[w[19:16]];
            end else if (w[26]) begin
                if (w[25:20] == 6'd2) return steps;
                if (w[25:20] == 6'd3) begin
                    fs = w[1];
                    se = w[0];
                end
            end
            ip = nextIp;
        end
        return -1;
    endfunction

    // Compares each DUT store with the next expected one and updates the memory model
    always @(negedge iClk) begin
        if (!rst && memWrite) begin
            if (halt) stopRun("a store happened after halt");
            if (storeCount >= expAddr.size()) stopRun("the DUT made more stores than expected");
            checkValue("memAddr", memAddr, expAddr[storeCount]);
            checkValue("memWrData", memWrData, expData[storeCount]);
            mem[memAddr] = memWrData;
            memVersion++;
            storeCount++;
        end
    end

    task automatic storeReg(input int rg);
        prog.push_back(memInstr(1, 0, rg, 32'h1000 + slot));
        slot++;
    endtask

    // Full 32-bit random value in two direct instructions
    task automatic setReg(input int rg);
        prog.push_back(directInstr(0, rg, 6, $urandom_range(0, 20'hFFFFF)));
        prog.push_back(directInstr(1, rg, 0, $urandom_range(0, 20'hFFFFF)));
    endtask

    task automatic runProgram(input string name);
        int steps;
        int cycles;
        @(negedge iClk);
        rst = 1'b1;
        prog.push_back(coreInstr(2, 0));
        foreach (prog[i]) mem[i] = prog[i];
        memVersion++;
        steps = runReference();
        if (steps < 0) stopRun({"reference never reached halt in ", name});
        storeCount = 0;
        repeat (3) begin
            @(negedge iClk);
            checkValue("halt", {31'h0, halt}, 32'h0);
            checkValue("memWrite", {31'h0, memWrite}, 32'h0);
        end
        rst = 1'b0;
        cycles = 0;
        while (!halt) begin
            @(negedge iClk);
            cycles++;
            if (cycles > 5 * steps + 20) stopRun({"halt never arrived in ", name});
        end
        checkValue("halt cycles", 32'(cycles), 32'(5 * steps + 1));
        repeat (8) begin
            @(negedge iClk);
            checkValue("halt", {31'h0, halt}, 32'h1);
        end
        checkValue("store count", 32'(storeCount), 32'(expAddr.size()));
        prog.delete();
        mem.delete();
        slot = 0;
    endtask

    initial begin
        iClk = 1'b0;
        rst = 1'b1;
        memVersion = 1;
        storeCount = 0;
        slot = 0;
        void'($urandom(66248));

        // ALU operations with small and large shift operands
        prog.push_back(coreInstr(3, 2));
        for (int round = 0; round < 2; round++) begin
            setReg(1);
            if (round == 0) prog.push_back(directInstr(0, 2, 0, $urandom_range(0, 40)));
            else setReg(2);
            for (int op = 0; op < 12; op++) begin
                prog.push_back(aluInstr(0, op, 3, 1, 2, 0));
                storeReg(3);
                prog.push_back(aluInstr(1, op, 4, 1, $urandom_range(0, 15),
                    $urandom_range(0, 255)));
                storeReg(4);
            end
        end
        runProgram("alu");

        // A taken branch skips the marker store
        prog.push_back(coreInstr(3, 2));
        for (int cond = 0; cond < 16; cond++) begin
            setReg(1);
            if (cond % 3 == 1) prog.push_back(moveInstr(2, 1));
            else setReg(2);
            // XOR of equal operands sets the zero flag
            prog.push_back(aluInstr(0, (cond % 3 == 1) ? 4 : cond % 2, 5, 1, 2, 0));
            prog.push_back(directInstr(0, 6, 0, 32'h100 + cond));
            prog.push_back(branchInstr(cond, 0, prog.size() + 2));
            storeReg(6);
            storeReg(5);
        end
        runProgram("branch");

        // Loads and stores with both offset extensions
        for (int i = 0; i < 16; i++) mem[32'h3000 + i] = $urandom;
        prog.push_back(directInstr(0, 8, 0, 32'h3008));
        prog.push_back(memInstr(0, 8, 9, 3));
        storeReg(9);
        prog.push_back(memInstr(0, 8, 12, 32'hFFFFD));
        storeReg(12);
        prog.push_back(coreInstr(3, 1));
        prog.push_back(memInstr(0, 8, 10, 32'hFFFFD));
        storeReg(10);
        prog.push_back(memInstr(0, 8, 11, 32'hFFFFF));
        storeReg(11);
        prog.push_back(memInstr(0, 0, 13, 32'h1000 + slot - 1));
        storeReg(13);
        runProgram("load/store");

        // Direct set, direct OR and moves
        for (int sh = 0; sh < 8; sh++) begin
            prog.push_back(directInstr(0, 1, sh, $urandom_range(0, 20'hFFFFF)));
            storeReg(1);
            prog.push_back(directInstr(1, 1, $urandom_range(0, 15), $urandom_range(0, 20'hFFFFF)));
            storeReg(1);
            prog.push_back(moveInstr(2 + sh, 1));
            storeReg(2 + sh);
        end
        runProgram("direct/move");

        // Seeded random program
        prog.push_back(coreInstr(3, $urandom_range(0, 3)));
        for (int i = 1; i < 5; i++) setReg(i);
        for (int i = 0; i < 40; i++) begin
            case ($urandom_range(0, 4))
                0: prog.push_back(aluInstr(0, $urandom_range(0, 11), $urandom_range(1, 15),
                    $urandom_range(0, 15), $urandom_range(0, 15), 0));
                1: prog.push_back(aluInstr(1, $urandom_range(0, 11), $urandom_range(1, 15),
                    $urandom_range(0, 15), $urandom_range(0, 15), $urandom_range(0, 255)));
                2: prog.push_back(directInstr($urandom_range(0, 1), $urandom_range(1, 15),
                    $urandom_range(0, 15), $urandom_range(0, 20'hFFFFF)));
                3: prog.push_back(moveInstr($urandom_range(1, 15), $urandom_range(0, 15)));
                default: storeReg($urandom_range(0, 15));
            endcase
        end
        for (int i = 1; i < 16; i++) storeReg(i);
        runProgram("random");

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== build.f ====
rtl/coreDefsPkg.sv
rtl/regPortIf.sv
rtl/generalRegs.sv
rtl/instrDecoder.sv
rtl/aluUnit.sv
rtl/statusRegs.sv
rtl/stepSequencer.sv
rtl/cpuCore.sv
verif/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module cpuCoreTb -f build.f -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "PASS: all tests" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
